// File: flist.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/rv_dec_if.sv
hdl/rv_mem_if.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
verification/rv_core_asserts.sv
verification/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module rv_core_tb \
	-o rv_core_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/rv_core_sim > sim.log 2>&1

grep -qx "TEST PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: verification/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	logic clk;
	logic rstn;
	word_t araddr, rdata, awaddr, wdata;
	logic arvalid, arready, rvalid, rready;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	strb_t wstrb;
	logic retire, halted;

	word_t mem [0:1023];
	word_t got_addr[$], got_data[$], exp_addr[$], exp_data[$];
	strb_t got_strb[$], exp_strb[$];
	integer seed;
	bit random_delays;
	int retire_count;
	int errors;
	word_t prog_pc;
	word_t store_ptr;

	// memory model state
	int ar_wait, r_wait, aw_wait, w_wait, b_wait;
	logic rd_pend, aw_done, w_done;
	word_t rd_addr, cap_addr, cap_data;
	strb_t cap_strb;

	rv_core DUT (.*);

	always #20 clk = ~clk;

	function automatic int pick_delay();
		if (!random_delays)
			return 0;
		return int'($unsigned($random(seed)) % 4);
	endfunction

	always @(posedge clk) begin
		#2;
		if (!rstn) begin
			{arready, rvalid, awready, wready, bvalid} = '0;
			{rd_pend, aw_done, w_done} = '0;
			ar_wait = 0;
			r_wait = 0;
			aw_wait = 0;
			w_wait = 0;
			b_wait = 0;
		end else begin
			if (arready) begin // address taken at last edge
				arready = 1'b0;
				rd_pend = 1'b1;
				r_wait = pick_delay();
			end else if (arvalid) begin
				if (ar_wait == 0) begin
					arready = 1'b1;
					rd_addr = araddr;
					ar_wait = pick_delay();
				end else ar_wait--;
			end
			if (rvalid) begin
				rvalid = 1'b0;
			end else if (rd_pend && rready) begin
				if (r_wait == 0) begin
					rvalid = 1'b1;
					rdata = mem[rd_addr[11:2]];
					rd_pend = 1'b0;
				end else r_wait--;
			end
			if (awready) begin
				awready = 1'b0;
				aw_done = 1'b1;
			end else if (awvalid && !aw_done) begin
				if (aw_wait == 0) begin
					awready = 1'b1;
					cap_addr = awaddr;
					aw_wait = pick_delay();
				end else aw_wait--;
			end
			if (wready) begin
				wready = 1'b0;
				w_done = 1'b1;
			end else if (wvalid && !w_done) begin
				if (w_wait == 0) begin
					wready = 1'b1;
					cap_data = wdata;
					cap_strb = wstrb;
					w_wait = pick_delay();
				end else w_wait--;
			end
			if (bvalid) begin
				bvalid = 1'b0;
			end else if (aw_done && w_done && bready) begin
				if (b_wait == 0) begin
					bvalid = 1'b1;
					for (int i = 0; i < 4; i++)
						if (cap_strb[i])
							mem[cap_addr[11:2]][8*i +: 8] = cap_data[8*i +: 8];
					got_addr.push_back(cap_addr);
					got_data.push_back(cap_data);
					got_strb.push_back(cap_strb);
					aw_done = 1'b0;
					w_done = 1'b0;
					b_wait = pick_delay();
				end else b_wait--;
			end
		end
	end

	always @(posedge clk) begin
		if (!rstn)
			retire_count <= 0;
		else if (retire)
			retire_count <= retire_count + 1;
	end

	task automatic fail_now();
		errors++;
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_strb(input string name, input strb_t got, input strb_t exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_bool(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s got %h expected %h", name, got, exp);
			fail_now();
		end
	endtask

	// instruction encoders
	function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3, reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, opc_op};
	endfunction

	function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
			reg_idx_t rd, opcode_e opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], opc_store}; // base is x0
	endfunction

	function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd, opcode_e opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	function automatic word_t lane_mask(strb_t s);
		return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
	endfunction

	function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic word_t load_value(word_t w, logic [2:0] f3, int k);
		word_t v;
		v = w >> (8 * k);
		case (f3)
			3'b000: return {{24{v[7]}}, v[7:0]};
			3'b100: return {24'd0, v[7:0]};
			3'b001: return {{16{v[15]}}, v[15:0]};
			3'b101: return {16'd0, v[15:0]};
			default: return v;
		endcase
	endfunction

	task automatic emit(input word_t ins);
		mem[prog_pc[11:2]] = ins;
		prog_pc += 4;
	endtask

	task automatic expect_store(input word_t addr, input word_t data, input strb_t strb);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	task automatic store_reg(input reg_idx_t rs, input word_t exp);
		emit(s_type(store_ptr[11:0], rs, 3'b010));
		expect_store(store_ptr, exp, 4'hf);
		store_ptr += 4;
	endtask

	task automatic alu_case(input word_t ins, input word_t exp);
		emit(ins);
		store_reg(5, exp);
	endtask

	task automatic begin_test(input bit with_delays, input word_t stores_at);
		@(posedge clk);
		#2;
		rstn = 1'b0;
		random_delays = with_delays;
		for (int i = 0; i < 1024; i++)
			mem[i] = 32'hc3ff_0000 ^ (32'(i) << 2); // never a real program
		got_addr.delete();
		got_data.delete();
		got_strb.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_strb.delete();
		prog_pc = '0;
		store_ptr = stores_at;
	endtask

	task automatic run_program();
		int n;
		emit(32'h0000_0000); // stop
		repeat (16) @(posedge clk);
		#2;
		rstn = 1'b1;
		n = 0;
		while (!halted) begin
			@(posedge clk);
			#1;
			n++;
			if (n > 5000) begin
				$display("timeout: the core never halted");
				fail_now();
			end
		end
	endtask

	task automatic check_stores();
		check_word("store count", got_addr.size(), exp_addr.size());
		foreach (exp_addr[i]) begin
			check_word("awaddr", got_addr[i], exp_addr[i]);
			check_strb("wstrb", got_strb[i], exp_strb[i]);
			check_word("wdata", got_data[i] & lane_mask(exp_strb[i]),
				exp_data[i] & lane_mask(exp_strb[i]));
		end
	endtask

	task automatic alu_program();
		word_t a, b;
		a = 32'h1234_5678;
		b = 32'hffff_fffb;
		emit(u_type(20'h12345, 1, opc_lui));
		emit(i_type(12'h678, 1, 3'b000, 1, opc_op_imm));
		emit(i_type(12'hffb, 0, 3'b000, 2, opc_op_imm));
		emit(i_type(12'd35, 0, 3'b000, 4, opc_op_imm)); // shift by 3
		alu_case(r_type(7'h00, 2, 1, 3'b000, 5), a + b);
		alu_case(r_type(7'h20, 2, 1, 3'b000, 5), a - b);
		alu_case(r_type(7'h00, 1, 2, 3'b010, 5), word_t'($signed(b) < $signed(a)));
		alu_case(r_type(7'h00, 2, 1, 3'b011, 5), word_t'(a < b));
		alu_case(r_type(7'h00, 2, 1, 3'b100, 5), a ^ b);
		alu_case(r_type(7'h00, 2, 1, 3'b110, 5), a | b);
		alu_case(r_type(7'h00, 2, 1, 3'b111, 5), a & b);
		alu_case(r_type(7'h00, 4, 1, 3'b001, 5), a << 3);
		alu_case(r_type(7'h00, 4, 2, 3'b101, 5), b >> 3);
		alu_case(r_type(7'h20, 4, 2, 3'b101, 5), word_t'($signed(b) >>> 3));
		alu_case(i_type(12'h009, 1, 3'b001, 5, opc_op_imm), a << 9);
		alu_case(i_type(12'h404, 2, 3'b101, 5, opc_op_imm), word_t'($signed(b) >>> 4));
		alu_case(i_type(12'hfff, 1, 3'b011, 5, opc_op_imm), word_t'(a < 32'hffff_ffff));
		alu_case(i_type(12'h0f0, 1, 3'b100, 5, opc_op_imm), a ^ 32'h0000_00f0);
		alu_case(i_type(12'h800, 2, 3'b111, 5, opc_op_imm), b & 32'hffff_f800);
		alu_case(u_type(20'h00001, 5, opc_auipc), prog_pc + 32'h1000);
	endtask

	task automatic test_alu(input bit with_delays);
		begin_test(with_delays, 32'h200);
		alu_program();
		run_program();
		check_stores();
	endtask

	task automatic test_control();
		logic [2:0] f3s [6];
		word_t val [3];
		reg_idx_t rs1, rs2;
		word_t p;
		f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		val = '{32'd0, 32'd5, 32'hffff_fffd};
		begin_test(0, 32'h200);
		emit(i_type(12'd5, 0, 3'b000, 1, opc_op_imm));
		emit(i_type(12'hffd, 0, 3'b000, 2, opc_op_imm));
		foreach (f3s[f]) begin
			for (int k = 0; k < 3; k++) begin
				rs1 = (k == 1) ? 5'd2 : 5'd1;
				rs2 = (k == 0) ? 5'd2 : 5'd1;
				emit(i_type(12'd1, 0, 3'b000, 5, opc_op_imm));
				emit(b_type(13'd8, rs2, rs1, f3s[f])); // skip next if taken
				emit(i_type(12'd2, 0, 3'b000, 5, opc_op_imm));
				store_reg(5, branch_taken(f3s[f], val[rs1], val[rs2]) ? 32'd1 : 32'd2);
			end
		end
		emit(i_type(12'd7, 0, 3'b000, 5, opc_op_imm));
		p = prog_pc;
		emit(j_type(21'd8, 6));
		emit(i_type(12'd9, 0, 3'b000, 5, opc_op_imm));
		store_reg(5, 32'd7);
		store_reg(6, p + 4);
		p = prog_pc;
		emit(i_type(12'(p + 12), 0, 3'b000, 7, opc_op_imm));
		emit(i_type(12'd0, 7, 3'b000, 8, opc_jalr));
		emit(i_type(12'd11, 0, 3'b000, 5, opc_op_imm));
		store_reg(8, p + 8);
		store_reg(5, 32'd7);
		run_program();
		check_stores();
	endtask

	task automatic test_narrow_stores();
		begin_test(0, 32'h300);
		emit(u_type(20'ha1b2c, 1, opc_lui));
		emit(i_type(12'h3d4, 1, 3'b000, 1, opc_op_imm));
		for (int k = 0; k < 4; k++) begin
			emit(s_type(12'(32'h300 + k), 1, 3'b000));
			expect_store(32'h300, 32'h0000_00d4 << (8 * k), strb_t'(4'b0001 << k));
		end
		for (int k = 0; k < 4; k += 2) begin
			emit(s_type(12'(32'h310 + k), 1, 3'b001));
			expect_store(32'h310, 32'h0000_c3d4 << (8 * k), strb_t'(4'b0011 << k));
		end
		run_program();
		check_stores();
	endtask

	task automatic test_loads();
		word_t w;
		w = 32'h80f1_7f9e;
		begin_test(0, 32'h500);
		mem[32'h400 >> 2] = w;
		for (int k = 0; k < 4; k++) begin
			alu_case(i_type(12'(32'h400 + k), 0, 3'b000, 5, opc_load), load_value(w, 3'b000, k));
			alu_case(i_type(12'(32'h400 + k), 0, 3'b100, 5, opc_load), load_value(w, 3'b100, k));
		end
		for (int k = 0; k < 4; k += 2) begin
			alu_case(i_type(12'(32'h400 + k), 0, 3'b001, 5, opc_load), load_value(w, 3'b001, k));
			alu_case(i_type(12'(32'h400 + k), 0, 3'b101, 5, opc_load), load_value(w, 3'b101, k));
		end
		alu_case(i_type(12'h400, 0, 3'b010, 5, opc_load), w);
		run_program();
		check_stores();
	endtask

	task automatic check_quiet(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			#1;
			check_bool("arvalid", arvalid, 1'b0);
			check_bool("awvalid", awvalid, 1'b0);
			check_bool("halted", halted, 1'b1);
		end
	endtask

	task automatic test_halt(input bit misaligned);
		begin_test(0, 32'h600);
		alu_case(i_type(12'h055, 0, 3'b000, 5, opc_op_imm), 32'h55);
		if (misaligned)
			emit(i_type(12'h602, 0, 3'b010, 6, opc_load));
		else
			emit(32'hffff_ffff); // no such opcode
		run_program();
		check_stores();
		check_word("retire count", retire_count, 2);
		check_quiet(40);
	endtask

	initial begin
		clk = 1'b0;
		rstn = 1'b0;
		{arready, rvalid, awready, wready, bvalid} = '0;
		rdata = '0;
		seed = 32'h33831943;
		random_delays = 1'b0;
		errors = 0;
		test_alu(0);
		test_control();
		test_narrow_stores();
		test_loads();
		test_halt(0);
		test_halt(1);
		test_alu(1); // same values under back-pressure
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: verification/rv_core_asserts.sv
`timescale 1ns/1ns

module rv_core_asserts (
	input logic clk,
	input logic rstn,
	input logic arvalid,
	input logic arready,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic retire,
	input logic halted
);

	// a request stays up until it is accepted
	ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

	aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

	retire_pulse: assert property (@(posedge clk) disable iff (!rstn)
		retire |=> !retire)
		else $error("retire longer than one cycle");

	// halted core stays off the bus
	halt_quiet: assert property (@(posedge clk) disable iff (!rstn)
		halted |=> !$rose(arvalid) && !$rose(awvalid) && !$rose(wvalid))
		else $error("bus request raised while halted");

endmodule

bind rv_core rv_core_asserts u_asserts (
	.clk, .rstn, .arvalid, .arready, .awvalid, .awready, .wvalid, .retire, .halted
);

// File: hdl/rv_core.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_core (
	input logic clk,
	input logic rstn,
	output rv_core_pkg::word_t araddr,
	output logic arvalid,
	input logic arready,
	input rv_core_pkg::word_t rdata,
	input logic rvalid,
	output logic rready,
	output rv_core_pkg::word_t awaddr,
	output logic awvalid,
	input logic awready,
	output rv_core_pkg::word_t wdata,
	output rv_core_pkg::strb_t wstrb,
	output logic wvalid,
	input logic wready,
	input logic bvalid,
	output logic bready,
	output logic retire,
	output logic halted
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	state_e state;
	word_t pc;
	word_t instr;
	word_t load_data;
	word_t rs1_data;
	word_t rs2_data;
	word_t alu_result;
	word_t wb_data;
	word_t next_pc;
	word_t pc_plus4;
	logic exec2; // second exec cycle
	logic req_sent; // lsu request out for this state
	logic is_load;
	logic is_store;

	rv_dec_if dec_bus();
	rv_mem_if mem_bus();

	rv_decoder u_dec (.clk, .rstn, .load(state == st_decode), .instr, .dec(dec_bus));

	rv_regfile u_rf (
		.clk, .rstn,
		.rs1_idx(dec_bus.rs1), .rs2_idx(dec_bus.rs2),
		.rs1_data, .rs2_data,
		.rd_idx(dec_bus.rd), .rd_we(state == st_write), .rd_data(wb_data)
	);

	rv_alu u_alu (.clk, .rstn, .src1(rs1_data), .rs2_data, .dec(dec_bus), .result(alu_result));

	rv_lsu u_lsu (
		.clk, .rstn, .mem(mem_bus), .dec(dec_bus),
		.araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bvalid, .bready
	);

	assign is_load = dec_bus.op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
	assign is_store = dec_bus.op inside {op_sb, op_sh, op_sw};
	assign pc_plus4 = pc + 32'd4;
	assign retire = (state == st_write);
	assign halted = (state == st_halt);

	always_comb begin
		case (dec_bus.op)
			op_lui: wb_data = dec_bus.imm;
			op_auipc: wb_data = pc + dec_bus.imm;
			op_jal, op_jalr: wb_data = pc_plus4; // link
			op_lb, op_lh, op_lw, op_lbu, op_lhu: wb_data = load_data;
			default: wb_data = alu_result;
		endcase
		case (dec_bus.op)
			op_jal: next_pc = pc + dec_bus.imm;
			op_jalr: next_pc = (rs1_data + dec_bus.imm) & ~32'd1;
			op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
				next_pc = (alu_result != '0) ? pc + dec_bus.imm : pc_plus4;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_wait;
			pc <= `RESET_PC;
			exec2 <= 1'b0;
			req_sent <= 1'b0;
			mem_bus.start <= 1'b0;
		end else begin
			mem_bus.start <= 1'b0;
			case (state)
				st_wait: state <= st_fetch;
				st_fetch:
					if (!req_sent) begin
						mem_bus.start <= 1'b1;
						mem_bus.kind <= kind_fetch;
						mem_bus.addr <= pc;
						req_sent <= 1'b1;
					end else if (mem_bus.done) begin
						req_sent <= 1'b0;
						instr <= mem_bus.rdata;
						state <= mem_bus.misaligned ? st_halt : st_decode;
					end
				st_decode: state <= st_exec;
				st_exec:
					if (dec_bus.op == op_illegal) begin
						state <= st_halt;
					end else if (!exec2) begin
						exec2 <= 1'b1;
					end else begin
						exec2 <= 1'b0;
						state <= (is_load || is_store) ? st_mem : st_write;
					end
				st_mem:
					if (!req_sent) begin
						mem_bus.start <= 1'b1;
						mem_bus.kind <= is_store ? kind_store : kind_load;
						mem_bus.addr <= alu_result; // rs1 + imm
						mem_bus.wdata <= rs2_data;
						req_sent <= 1'b1;
					end else if (mem_bus.done) begin
						req_sent <= 1'b0;
						load_data <= mem_bus.rdata;
						state <= mem_bus.misaligned ? st_halt : st_write;
					end
				st_write: begin
					pc <= next_pc;
					state <= st_fetch;
				end
				default: state <= st_halt; // held until reset
			endcase
		end
	end

endmodule

// File: hdl/rv_lsu.sv
`timescale 1ns/1ns

module rv_lsu (
	input logic clk,
	input logic rstn,
	rv_mem_if.lsu mem,
	rv_dec_if.lsu dec,
	output rv_core_pkg::word_t araddr,
	output logic arvalid,
	input logic arready,
	input rv_core_pkg::word_t rdata,
	input logic rvalid,
	output logic rready,
	output rv_core_pkg::word_t awaddr,
	output logic awvalid,
	input logic awready,
	output rv_core_pkg::word_t wdata,
	output rv_core_pkg::strb_t wstrb,
	output logic wvalid,
	input logic wready,
	input logic bvalid,
	output logic bready
);
	import rv_core_pkg::*;

	typedef enum logic [2:0] {ls_idle, ls_ar, ls_r, ls_w, ls_b} lsu_state_e;

	lsu_state_e ls_state;
	mem_kind_e kind_q;
	logic [1:0] off_q; // byte lane of the access
	mem_size_e size_eff;
	logic mis;
	word_t lane;
	word_t load_ext;
	word_t st_data;
	strb_t st_strb;

	// fetches are always words whatever the decoder holds
	assign size_eff = (mem.kind == kind_fetch) ? size_word : dec.mem_size;
	assign mis = (size_eff == size_half && mem.addr[0]) ||
		(size_eff == size_word && mem.addr[1:0] != 2'b00);

	always_comb begin
		lane = rdata >> {off_q, 3'b000};
		case (dec.mem_size)
			size_byte: load_ext = dec.mem_unsigned ? {24'd0, lane[7:0]} :
				{{24{lane[7]}}, lane[7:0]};
			size_half: load_ext = dec.mem_unsigned ? {16'd0, lane[15:0]} :
				{{16{lane[15]}}, lane[15:0]};
			default: load_ext = lane;
		endcase
		if (kind_q == kind_fetch)
			load_ext = rdata;
	end

	always_comb begin
		st_data = mem.wdata;
		st_strb = 4'b1111;
		if (dec.mem_size == size_byte) begin
			st_data = {24'd0, mem.wdata[7:0]};
			st_strb = 4'b0001;
		end else if (dec.mem_size == size_half) begin
			st_data = {16'd0, mem.wdata[15:0]};
			st_strb = 4'b0011;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ls_state <= ls_idle;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			mem.done <= 1'b0;
		end else begin
			mem.done <= 1'b0;
			case (ls_state)
				ls_idle:
					if (mem.start) begin
						kind_q <= mem.kind;
						off_q <= mem.addr[1:0];
						mem.misaligned <= mis;
						if (mis) begin
							mem.done <= 1'b1; // no bus transaction
						end else if (mem.kind == kind_store) begin
							awaddr <= {mem.addr[31:2], 2'b00};
							wdata <= st_data << {mem.addr[1:0], 3'b000};
							wstrb <= st_strb << mem.addr[1:0];
							awvalid <= 1'b1;
							wvalid <= 1'b1;
							ls_state <= ls_w;
						end else begin
							araddr <= {mem.addr[31:2], 2'b00};
							arvalid <= 1'b1;
							ls_state <= ls_ar;
						end
					end
				ls_ar:
					if (arready) begin
						arvalid <= 1'b0;
						rready <= 1'b1;
						ls_state <= ls_r;
					end
				ls_r:
					if (rvalid) begin
						rready <= 1'b0;
						mem.rdata <= load_ext;
						mem.done <= 1'b1;
						ls_state <= ls_idle;
					end
				ls_w: begin
					if (awready)
						awvalid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if (!awvalid && !wvalid) begin // both channels accepted
						bready <= 1'b1;
						ls_state <= ls_b;
					end
				end
				default:
					if (bvalid) begin
						bready <= 1'b0;
						mem.done <= 1'b1;
						ls_state <= ls_idle;
					end
			endcase
		end
	end

endmodule

// File: hdl/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
	input logic clk,
	input logic rstn,
	input rv_core_pkg::word_t src1,
	input rv_core_pkg::word_t rs2_data,
	rv_dec_if.alu dec,
	output rv_core_pkg::word_t result
);
	import rv_core_pkg::*;

	word_t src2;
	logic [4:0] shamt;
	word_t r_add, r_sub, r_xor, r_or, r_and;
	word_t r_sll, r_srl, r_sra;
	logic r_lt, r_ltu, r_eq;

	assign src2 = dec.use_imm ? dec.imm : rs2_data;
	assign shamt = src2[4:0];

	// stage 1 registers every candidate
	always_ff @(posedge clk) begin
		r_add <= src1 + src2;
		r_sub <= src1 - src2;
		r_xor <= src1 ^ src2;
		r_or <= src1 | src2;
		r_and <= src1 & src2;
		r_sll <= src1 << shamt;
		r_srl <= src1 >> shamt;
		r_sra <= word_t'($signed(src1) >>> shamt);
		r_lt <= $signed(src1) < $signed(src2);
		r_ltu <= src1 < src2;
		r_eq <= src1 == src2;
	end

	// stage 2 picks one
	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			case (dec.alu_op)
				alu_sub: result <= r_sub;
				alu_xor: result <= r_xor;
				alu_or: result <= r_or;
				alu_and: result <= r_and;
				alu_sll: result <= r_sll;
				alu_srl: result <= r_srl;
				alu_sra: result <= r_sra;
				alu_slt, alu_lt: result <= word_t'(r_lt);
				alu_sltu, alu_ltu: result <= word_t'(r_ltu);
				alu_ge: result <= word_t'(!r_lt);
				alu_geu: result <= word_t'(!r_ltu);
				alu_eq: result <= word_t'(r_eq);
				alu_ne: result <= word_t'(!r_eq);
				default: result <= r_add;
			endcase
		end
	end

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ns
`include "rv_macros.svh"

module rv_regfile (
	input logic clk,
	input logic rstn,
	input rv_core_pkg::reg_idx_t rs1_idx,
	input rv_core_pkg::reg_idx_t rs2_idx,
	output rv_core_pkg::word_t rs1_data,
	output rv_core_pkg::word_t rs2_data,
	input rv_core_pkg::reg_idx_t rd_idx,
	input logic rd_we,
	input rv_core_pkg::word_t rd_data
);
	import rv_core_pkg::*;

	word_t regs [`NREGS];

	always_ff @(posedge clk) begin
		rs1_data <= (rs1_idx == '0) ? '0 : regs[rs1_idx];
		rs2_data <= (rs2_idx == '0) ? '0 : regs[rs2_idx];
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < `NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd_idx != '0) begin // x0 stays zero
			regs[rd_idx] <= rd_data;
		end
	end

endmodule

// File: hdl/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
	input logic clk,
	input logic rstn,
	input logic load,
	input rv_core_pkg::word_t instr,
	rv_dec_if.dec dec
);
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	opcode_e opc;
	logic [2:0] funct3;
	logic [6:0] funct7;
	op_e op_n;
	alu_op_e alu_n;
	word_t imm_n;
	mem_size_e size_n;
	reg_idx_t rd_n;

	assign opc = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rd_n = (opc inside {opc_branch, opc_store}) ? '0 : instr[11:7];

	// source indices stay combinational so the regfile reads during decode
	assign dec.rs1 = (opc inside {opc_lui, opc_auipc, opc_jal}) ? '0 : instr[19:15];
	assign dec.rs2 = (opc inside {opc_branch, opc_store, opc_op}) ? instr[24:20] : '0;

	always_comb begin
		op_n = op_illegal;
		case (opc)
			opc_lui: op_n = op_lui;
			opc_auipc: op_n = op_auipc;
			opc_jal: op_n = op_jal;
			opc_jalr: op_n = (funct3 == 3'b000) ? op_jalr : op_illegal;
			opc_branch:
				case (funct3)
					3'b000: op_n = op_beq;
					3'b001: op_n = op_bne;
					3'b100: op_n = op_blt;
					3'b101: op_n = op_bge;
					3'b110: op_n = op_bltu;
					3'b111: op_n = op_bgeu;
					default: op_n = op_illegal;
				endcase
			opc_load:
				case (funct3)
					3'b000: op_n = op_lb;
					3'b001: op_n = op_lh;
					3'b010: op_n = op_lw;
					3'b100: op_n = op_lbu;
					3'b101: op_n = op_lhu;
					default: op_n = op_illegal;
				endcase
			opc_store:
				case (funct3)
					3'b000: op_n = op_sb;
					3'b001: op_n = op_sh;
					3'b010: op_n = op_sw;
					default: op_n = op_illegal;
				endcase
			opc_op_imm:
				case (funct3)
					3'b000: op_n = op_addi;
					3'b010: op_n = op_slti;
					3'b011: op_n = op_sltiu;
					3'b100: op_n = op_xori;
					3'b110: op_n = op_ori;
					3'b111: op_n = op_andi;
					3'b001: op_n = (funct7 == 7'h00) ? op_slli : op_illegal;
					default: op_n = (funct7 == 7'h00) ? op_srli :
						(funct7 == 7'h20) ? op_srai : op_illegal;
				endcase
			opc_op:
				case ({funct7, funct3})
					{7'h00, 3'b000}: op_n = op_add;
					{7'h20, 3'b000}: op_n = op_sub;
					{7'h00, 3'b001}: op_n = op_sll;
					{7'h00, 3'b010}: op_n = op_slt;
					{7'h00, 3'b011}: op_n = op_sltu;
					{7'h00, 3'b100}: op_n = op_xor;
					{7'h00, 3'b101}: op_n = op_srl;
					{7'h20, 3'b101}: op_n = op_sra;
					{7'h00, 3'b110}: op_n = op_or;
					{7'h00, 3'b111}: op_n = op_and;
					default: op_n = op_illegal;
				endcase
			default: op_n = op_illegal;
		endcase
	end

	always_comb begin
		case (op_n)
			op_sub: alu_n = alu_sub;
			op_slt, op_slti: alu_n = alu_slt;
			op_sltu, op_sltiu: alu_n = alu_sltu;
			op_xor, op_xori: alu_n = alu_xor;
			op_or, op_ori: alu_n = alu_or;
			op_and, op_andi: alu_n = alu_and;
			op_sll, op_slli: alu_n = alu_sll;
			op_srl, op_srli: alu_n = alu_srl;
			op_sra, op_srai: alu_n = alu_sra;
			op_beq: alu_n = alu_eq;
			op_bne: alu_n = alu_ne;
			op_blt: alu_n = alu_lt;
			op_bge: alu_n = alu_ge;
			op_bltu: alu_n = alu_ltu;
			op_bgeu: alu_n = alu_geu;
			default: alu_n = alu_add; // loads and stores add base and offset
		endcase
		case (op_n)
			op_lb, op_lbu, op_sb: size_n = size_byte;
			op_lh, op_lhu, op_sh: size_n = size_half;
			default: size_n = size_word;
		endcase
	end

	always_comb begin
		case (opc)
			opc_lui, opc_auipc: imm_n = {instr[31:12], 12'd0};
			opc_jal: imm_n = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			opc_branch: imm_n = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			opc_store: imm_n = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			default: imm_n = {{21{instr[31]}}, instr[30:20]};
		endcase
		if (op_n inside {op_slli, op_srli, op_srai})
			imm_n = {27'd0, instr[24:20]}; // shamt only
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec.op <= op_illegal;
		end else if (load) begin
			dec.op <= op_n;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			dec.alu_op <= alu_n;
			dec.use_imm <= opc inside {opc_load, opc_store, opc_op_imm, opc_jalr};
			dec.rd <= rd_n;
			dec.imm <= imm_n;
			dec.mem_size <= size_n;
			dec.mem_unsigned <= op_n inside {op_lbu, op_lhu};
		end
	end

endmodule

// File: hdl/rv_mem_if.sv
`timescale 1ns/1ns

interface rv_mem_if;
	import rv_core_pkg::*;

	// request lasts a single cycle
	logic start;
	mem_kind_e kind;
	word_t addr;
	word_t wdata;

	// completion lasts a single cycle
	logic done;
	word_t rdata;
	logic misaligned;

	modport core (output start, kind, addr, wdata, input done, rdata, misaligned);
	modport lsu (input start, kind, addr, wdata, output done, rdata, misaligned);

endinterface

// File: hdl/rv_dec_if.sv
`timescale 1ns/1ns

interface rv_dec_if;
	import rv_isa_pkg::*;
	import rv_core_pkg::*;

	op_e op;
	alu_op_e alu_op;
	logic use_imm; // second alu operand is imm
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t imm;
	mem_size_e mem_size;
	logic mem_unsigned;

	modport dec (output op, alu_op, use_imm, rd, rs1, rs2, imm, mem_size, mem_unsigned);
	modport core (input op, rd, imm);
	modport alu (input alu_op, use_imm, imm);
	modport lsu (input mem_size, mem_unsigned);

endinterface

// File: hdl/rv_core_pkg.sv
`include "rv_macros.svh"

package rv_core_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`XLEN/8-1:0] strb_t;

	typedef enum logic [2:0] {
		st_wait, st_fetch, st_decode, st_exec, st_mem, st_write, st_halt
	} state_e;

	// compare ops give 0 or 1
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or, alu_and, alu_sll,
		alu_srl, alu_sra, alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	typedef enum logic [1:0] {kind_fetch, kind_load, kind_store} mem_kind_e;

	typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

endpackage

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

	// major opcodes of the base integer set
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011
	} opcode_e;

	// one value per decoded instruction
	typedef enum logic [5:0] {
		op_lui, op_auipc, op_jal, op_jalr,
		op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
		op_lb, op_lh, op_lw, op_lbu, op_lhu,
		op_sb, op_sh, op_sw,
		op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
		op_slli, op_srli, op_srai,
		op_add, op_sub, op_sll, op_slt, op_sltu,
		op_xor, op_srl, op_sra, op_or, op_and,
		op_illegal
	} op_e;

endpackage

// File: hdl/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and address width
`define XLEN 32

// integer register file
`define NREGS 32
`define REG_IDX_W 5

// first fetch address
`define RESET_PC 32'h0000_0000

`endif
